// File: hw/lsu_pkg.sv
package lsu_pkg;

    // ----------------------------------------
    // widths and vector types
    // ----------------------------------------
    localparam int unsigned XLEN          = 64;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [XLEN/8-1:0]        be_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [3:0]               lsu_op_t;
    // log2 of bytes moved
    typedef logic [1:0]               size_t;
    typedef logic [3:0]               cause_t;

    // ----------------------------------------
    // operator codes
    // ----------------------------------------
    // bit 3 set marks a store
    localparam lsu_op_t OP_LB  = 4'd0;
    localparam lsu_op_t OP_LBU = 4'd1;
    localparam lsu_op_t OP_LH  = 4'd2;
    localparam lsu_op_t OP_LHU = 4'd3;
    localparam lsu_op_t OP_LW  = 4'd4;
    localparam lsu_op_t OP_LWU = 4'd5;
    localparam lsu_op_t OP_LD  = 4'd6;
    localparam lsu_op_t OP_SB  = 4'd8;
    localparam lsu_op_t OP_SH  = 4'd9;
    localparam lsu_op_t OP_SW  = 4'd10;
    localparam lsu_op_t OP_SD  = 4'd11;

    // exception causes, mcause encoding
    localparam cause_t CAUSE_LD_MISALIGNED   = 4'd4;
    localparam cause_t CAUSE_LD_ACCESS_FAULT = 4'd5;
    localparam cause_t CAUSE_ST_MISALIGNED   = 4'd6;
    localparam cause_t CAUSE_ST_ACCESS_FAULT = 4'd7;

    // sv39 sign bits run from here up to 63
    localparam int unsigned SV39_TOP_LSB = 38;

    localparam int unsigned NR_WB_REGS_DEFAULT = 1;

    // transfer size straight from the operator code
    // loads keep it in bits 2:1, stores in bits 1:0
    function automatic size_t op_size(lsu_op_t op);
        if (op[3]) begin
            return op[1:0];
        end
        return op[2:1];
    endfunction

endpackage

// File: hw/lsu_req_if.sv
`timescale 1ns/10ps

interface lsu_req_if;
    import lsu_pkg::*;

    // one decoded request, no handshake
    logic      valid;
    word_t     vaddr;
    // store data, operand b
    word_t     wdata;
    be_t       be;
    lsu_op_t   op;
    trans_id_t trans_id;

    modport src (
        output valid,
        output vaddr,
        output wdata,
        output be,
        output op,
        output trans_id
    );

    modport dst (
        input valid,
        input vaddr,
        input wdata,
        input be,
        input op,
        input trans_id
    );

endinterface

// File: hw/lsu_agu.sv
`timescale 1ns/10ps

module lsu_agu (
    input  logic                lsu_valid_i,
    input  lsu_pkg::word_t      operand_a_i,
    input  lsu_pkg::word_t      operand_b_i,
    input  lsu_pkg::word_t      imm_i,
    input  lsu_pkg::lsu_op_t    op_i,
    input  lsu_pkg::trans_id_t  trans_id_i,
    lsu_req_if.src              req_o
);
    import lsu_pkg::*;

    word_t vaddr;
    size_t size;
    be_t   be;

    // ----------------------------------------
    // address generation
    // ----------------------------------------
    // two's complement sum, sign of imm comes for free
    assign vaddr = imm_i + operand_a_i;

    assign size = op_size(op_i);

    // ----------------------------------------
    // byte enables
    // ----------------------------------------
    always_comb begin : be_gen
        logic [3:0] first;
        logic [3:0] last;

        first = {1'b0, vaddr[2:0]};
        // one past the last byte, may run beyond the double word
        last  = first + (4'd1 << size);
        be    = '0;
        for (int i = 0; i < XLEN / 8; i++) begin
            if (4'(i) >= first && 4'(i) < last) begin
                be[i] = 1'b1;
            end
        end
    end

    // bytes past 7 simply fall off, alignment check catches those
    assign req_o.valid    = lsu_valid_i;
    assign req_o.vaddr    = vaddr;
    assign req_o.wdata    = operand_b_i;
    assign req_o.be       = be;
    assign req_o.op       = op_i;
    assign req_o.trans_id = trans_id_i;

endmodule

// File: hw/lsu_bypass.sv
`timescale 1ns/10ps

module lsu_bypass (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       flush_i,
    lsu_req_if.dst     req_i,
    input  logic       pop_ld_i,
    input  logic       pop_st_i,
    lsu_req_if.src     ctrl_o,
    output logic       ready_o
);
    import lsu_pkg::*;

    // ring state
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] cnt_q;
    logic [1:0] valid_q;

    // entry payload
    word_t     vaddr_q    [2];
    word_t     wdata_q    [2];
    be_t       be_q       [2];
    lsu_op_t   op_q       [2];
    trans_id_t trans_id_q [2];

    logic pop;
    logic empty;

    assign pop     = pop_ld_i | pop_st_i;
    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // ----------------------------------------
    // pointers, count and valid bits
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
            valid_q  <= 2'b00;
        end else if (flush_i) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
            valid_q  <= 2'b00;
        end else begin
            if (req_i.valid) begin
                wr_ptr_q          <= ~wr_ptr_q;
                valid_q[wr_ptr_q] <= 1'b1;
            end
            // pop comes last so a same-cycle pass-through leaves nothing behind
            if (pop) begin
                rd_ptr_q          <= ~rd_ptr_q;
                valid_q[rd_ptr_q] <= 1'b0;
            end
            cnt_q <= cnt_q + {1'b0, req_i.valid} - {1'b0, pop};
        end
    end

    // every valid request lands in the ring
    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            vaddr_q[wr_ptr_q]    <= req_i.vaddr;
            wdata_q[wr_ptr_q]    <= req_i.wdata;
            be_q[wr_ptr_q]       <= req_i.be;
            op_q[wr_ptr_q]       <= req_i.op;
            trans_id_q[wr_ptr_q] <= req_i.trans_id;
        end
    end

    // empty ring forwards the new request directly
    assign ctrl_o.valid    = empty ? req_i.valid    : valid_q[rd_ptr_q];
    assign ctrl_o.vaddr    = empty ? req_i.vaddr    : vaddr_q[rd_ptr_q];
    assign ctrl_o.wdata    = empty ? req_i.wdata    : wdata_q[rd_ptr_q];
    assign ctrl_o.be       = empty ? req_i.be       : be_q[rd_ptr_q];
    assign ctrl_o.op       = empty ? req_i.op       : op_q[rd_ptr_q];
    assign ctrl_o.trans_id = empty ? req_i.trans_id : trans_id_q[rd_ptr_q];

    a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cnt_q <= 2'd2);

    // dispatch retires one request per cycle
    a_pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_ld_i && pop_st_i));

endmodule

// File: hw/lsu_dispatch.sv
`timescale 1ns/10ps

module lsu_dispatch (
    input  logic                clk_i,
    input  logic                rst_ni,
    lsu_req_if.dst              req_i,
    input  logic                en_ld_st_translation_i,
    input  logic                mem_gnt_i,
    output logic                pop_ld_o,
    output logic                pop_st_o,
    // memory port
    output logic                mem_req_o,
    output logic                mem_we_o,
    output lsu_pkg::word_t      mem_addr_o,
    output lsu_pkg::be_t        mem_be_o,
    output lsu_pkg::word_t      mem_wdata_o,
    // writeback record, valid in the pop cycle
    output logic                wb_valid_o,
    output lsu_pkg::trans_id_t  wb_trans_id_o,
    output logic                wb_ex_valid_o,
    output lsu_pkg::cause_t     wb_cause_o,
    output lsu_pkg::word_t      wb_tval_o
);
    import lsu_pkg::*;

    logic   is_store;
    size_t  size;
    logic   misaligned;
    logic   non_canonical;
    logic   ex_valid;
    cause_t cause;
    logic   done;

    assign is_store = req_i.op[3];
    assign size     = op_size(req_i.op);

    // ----------------------------------------
    // alignment check
    // ----------------------------------------
    always_comb begin : align_check
        misaligned = 1'b0;
        unique case (size)
            // double
            2'd3: misaligned = (req_i.vaddr[2:0] != 3'b000);
            // word
            2'd2: misaligned = (req_i.vaddr[1:0] != 2'b00);
            // half
            2'd1: misaligned = req_i.vaddr[0];
            // byte never misaligned
            default: misaligned = 1'b0;
        endcase
    end

    // sv39 wants bits 63 down to 38 all equal
    assign non_canonical = en_ld_st_translation_i &&
        !((&req_i.vaddr[XLEN-1:SV39_TOP_LSB]) || !(|req_i.vaddr[XLEN-1:SV39_TOP_LSB]));

    assign ex_valid = req_i.valid && (misaligned || non_canonical);

    // access fault wins over misalignment
    always_comb begin : cause_sel
        if (non_canonical) begin
            cause = is_store ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
        end else begin
            cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        end
    end

    // ----------------------------------------
    // memory request
    // ----------------------------------------
    assign mem_req_o   = req_i.valid && !ex_valid;
    assign mem_we_o    = is_store;
    assign mem_addr_o  = req_i.vaddr;
    assign mem_be_o    = req_i.be;
    assign mem_wdata_o = req_i.wdata;

    // faulting requests leave at once, clean ones on grant
    assign done     = ex_valid || (mem_req_o && mem_gnt_i);
    assign pop_ld_o = done && !is_store;
    assign pop_st_o = done && is_store;

    // ----------------------------------------
    // writeback record
    // ----------------------------------------
    assign wb_valid_o    = done;
    assign wb_trans_id_o = req_i.trans_id;
    assign wb_ex_valid_o = ex_valid;
    assign wb_cause_o    = ex_valid ? cause : '0;
    // tval is the untranslated address
    assign wb_tval_o     = ex_valid ? req_i.vaddr : '0;

    // buffer keeps the request until grant
    // only a flush may withdraw it
    a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> !mem_req_o ||
            $stable({mem_addr_o, mem_we_o, mem_be_o, mem_wdata_o}));

endmodule

// File: hw/lsu_wb_pipe.sv
`timescale 1ns/10ps

module lsu_wb_pipe #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 1
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [WIDTH-1:0] d_i,
    output logic [WIDTH-1:0] d_o
);

    if (DEPTH == 0) begin : g_wire
        // no delay at all
        assign d_o = d_i;
    end else begin : g_regs
        logic [WIDTH-1:0] stage_q [DEPTH];

        // zeroed stages read as empty records
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage_q[i] <= '0;
                end
            end else begin
                stage_q[0] <= d_i;
                for (int i = 1; i < DEPTH; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign d_o = stage_q[DEPTH-1];
    end

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/10ps

module lsu_top #(
    parameter int unsigned NR_WB_REGS = lsu_pkg::NR_WB_REGS_DEFAULT
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    // issue side
    input  logic                lsu_valid_i,
    output logic                lsu_ready_o,
    input  lsu_pkg::word_t      operand_a_i,
    input  lsu_pkg::word_t      operand_b_i,
    input  lsu_pkg::word_t      imm_i,
    input  lsu_pkg::lsu_op_t    op_i,
    input  lsu_pkg::trans_id_t  trans_id_i,
    input  logic                en_ld_st_translation_i,
    // memory port
    output logic                mem_req_o,
    input  logic                mem_gnt_i,
    output logic                mem_we_o,
    output lsu_pkg::word_t      mem_addr_o,
    output lsu_pkg::be_t        mem_be_o,
    output lsu_pkg::word_t      mem_wdata_o,
    // writeback
    output logic                wb_valid_o,
    output lsu_pkg::trans_id_t  wb_trans_id_o,
    output logic                wb_ex_valid_o,
    output lsu_pkg::cause_t     wb_cause_o,
    output lsu_pkg::word_t      wb_tval_o
);
    import lsu_pkg::*;

    // valid, tag, ex flag, cause, tval
    localparam int unsigned WB_WIDTH = 1 + TRANS_ID_BITS + 1 + $bits(cause_t) + XLEN;

    logic      pop_ld;
    logic      pop_st;
    logic      wb_valid;
    trans_id_t wb_trans_id;
    logic      wb_ex_valid;
    cause_t    wb_cause;
    word_t     wb_tval;

    lsu_req_if agu_req ();
    lsu_req_if ctrl_req ();

    // ----------------------------------------
    // front end
    // ----------------------------------------
    lsu_agu u_agu (
        .lsu_valid_i (lsu_valid_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .op_i        (op_i),
        .trans_id_i  (trans_id_i),
        .req_o       (agu_req)
    );

    lsu_bypass u_bypass (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (flush_i),
        .req_i    (agu_req),
        .pop_ld_i (pop_ld),
        .pop_st_i (pop_st),
        .ctrl_o   (ctrl_req),
        .ready_o  (lsu_ready_o)
    );

    lsu_dispatch u_dispatch (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .req_i                  (ctrl_req),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .mem_gnt_i              (mem_gnt_i),
        .pop_ld_o               (pop_ld),
        .pop_st_o               (pop_st),
        .mem_req_o              (mem_req_o),
        .mem_we_o               (mem_we_o),
        .mem_addr_o             (mem_addr_o),
        .mem_be_o               (mem_be_o),
        .mem_wdata_o            (mem_wdata_o),
        .wb_valid_o             (wb_valid),
        .wb_trans_id_o          (wb_trans_id),
        .wb_ex_valid_o          (wb_ex_valid),
        .wb_cause_o             (wb_cause),
        .wb_tval_o              (wb_tval)
    );

    // writeback delay line
    lsu_wb_pipe #(
        .WIDTH (WB_WIDTH),
        .DEPTH (NR_WB_REGS)
    ) u_wb_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    ({wb_valid, wb_trans_id, wb_ex_valid, wb_cause, wb_tval}),
        .d_o    ({wb_valid_o, wb_trans_id_o, wb_ex_valid_o, wb_cause_o, wb_tval_o})
    );

endmodule

// File: dv/tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int unsigned NR_WB_REGS = 2;
    // aligned 33, misaligned 16, translation 16, back-pressure 40, flush 4
    localparam int unsigned N_REQS  = 33 + 16 + 16 + 40 + 4;
    localparam int unsigned TIMEOUT = N_REQS * 20 + 200;
    localparam lsu_op_t OPS [11] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD,
                                     OP_SB, OP_SH, OP_SW, OP_SD};

    // expected outcome of one request
    typedef struct packed {
        word_t       addr;
        be_t         be;
        logic        we;
        word_t       wdata;
        trans_id_t   id;
        logic        ex;
        cause_t      cause;
        logic [31:0] due;
    } exp_t;

    logic      clk_i, rst_ni, flush_i, lsu_valid_i, lsu_ready_o;
    word_t     operand_a_i, operand_b_i, imm_i;
    lsu_op_t   op_i;
    trans_id_t trans_id_i;
    logic      en_ld_st_translation_i;
    logic      mem_req_o, mem_gnt_i, mem_we_o;
    word_t     mem_addr_o, mem_wdata_o;
    be_t       mem_be_o;
    logic      wb_valid_o, wb_ex_valid_o;
    trans_id_t wb_trans_id_o;
    cause_t    wb_cause_o;
    word_t     wb_tval_o;

    exp_t        mem_q [$];
    exp_t        wb_q  [$];
    logic [31:0] lfsr_q;
    int unsigned cyc = 0;
    int unsigned err_cnt = 0;
    int unsigned check_cnt = 0;
    int unsigned test_cnt = 0;
    int unsigned test_err0 = 0;
    logic        gnt_random, gnt_level;
    trans_id_t   next_id;
    // payload seen while a request waits for grant
    logic        waiting = 1'b0;
    logic        hold_we;
    word_t       hold_addr, hold_wdata;
    be_t         hold_be;

    lsu_top #(.NR_WB_REGS(NR_WB_REGS)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // random source and reference model
    // ----------------------------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(int unsigned n);
        word_t v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[XLEN-2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // small signed offset with low bits chosen by caller
    function automatic word_t small_imm(logic [2:0] off);
        word_t r;
        r = rand_bits(5);
        return {{56{r[4]}}, r[4:0], off};
    endfunction

    function automatic lsu_op_t rand_op();
        word_t      r;
        logic [3:0] idx;
        r   = rand_bits(4);
        idx = r[3:0] % 4'd11;
        return OPS[idx];
    endfunction

    function automatic size_t size_of(lsu_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 2'd0;
            OP_LH, OP_LHU, OP_SH: return 2'd1;
            OP_LW, OP_LWU, OP_SW: return 2'd2;
            default:              return 2'd3;
        endcase
    endfunction

    function automatic exp_t ref_lsu(word_t a, word_t b, word_t imm, lsu_op_t op,
                                     trans_id_t id, logic en);
        exp_t        e;
        int          lo;
        int          n;
        logic [15:0] span;
        logic        mis;
        logic        bad;
        e       = '0;
        e.addr  = imm + a;
        e.we    = op[3];
        e.wdata = b;
        e.id    = id;
        lo      = 32'(e.addr[2:0]);
        n       = 1 << size_of(op);
        // bytes past the double word are cut off
        span    = ((16'd1 << n) - 16'd1) << lo;
        e.be    = span[7:0];
        mis  = (lo % n) != 0;
        // sv39 sign bits 63 down to 38
        bad  = en && (e.addr[63:38] != '0) && (e.addr[63:38] != '1);
        e.ex = mis || bad;
        if (bad) begin
            e.cause = e.we ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
        end else begin
            e.cause = e.we ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        end
        return e;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic report_error(string msg);
        err_cnt++;
        $display("Error @%0t: %s", $time, msg);
    endtask

    task automatic note_failure(string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        check_cnt++;
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_mem(string what, be_t got, be_t exp);
        check_cnt++;
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_wb_id(string what, trans_id_t got, trans_id_t exp);
        check_cnt++;
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_cause(string what, cause_t got, cause_t exp);
        check_cnt++;
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        check_cnt++;
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // ----------------------------------------
    // scoreboard sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk_i) begin : compare
        exp_t e;
        cyc = cyc + 1;
        if (rst_ni) begin
            if (waiting) begin
                check_flag("lsu_ready_o while waiting", lsu_ready_o, 1'b0);
                check_flag("mem_req_o while waiting", mem_req_o, 1'b1);
                check_word("held mem_addr_o", mem_addr_o, hold_addr);
                check_word("held mem_wdata_o", mem_wdata_o, hold_wdata);
                check_mem("held mem_be_o", mem_be_o, hold_be);
                check_flag("held mem_we_o", mem_we_o, hold_we);
            end
            // new request enters an empty buffer
            if (lsu_valid_i && lsu_ready_o) begin
                e = ref_lsu(operand_a_i, operand_b_i, imm_i, op_i, trans_id_i,
                            en_ld_st_translation_i);
                if (e.ex) begin
                    check_flag("mem_req_o on faulting access", mem_req_o, 1'b0);
                    e.due = cyc + NR_WB_REGS;
                    wb_q.push_back(e);
                end else begin
                    mem_q.push_back(e);
                end
            end
            if (mem_req_o && mem_gnt_i) begin
                if (mem_q.size() == 0) begin
                    note_failure("memory transfer seen with no request pending");
                end else begin
                    e = mem_q.pop_front();
                    check_word("mem_addr_o", mem_addr_o, e.addr);
                    check_mem("mem_be_o", mem_be_o, e.be);
                    check_flag("mem_we_o", mem_we_o, e.we);
                    if (e.we) check_word("mem_wdata_o", mem_wdata_o, e.wdata);
                    e.due = cyc + NR_WB_REGS;
                    wb_q.push_back(e);
                end
            end
            // buffered request dropped at the next edge
            if (flush_i && !lsu_ready_o && mem_q.size() != 0) begin
                e = mem_q.pop_back();
            end
            waiting    = mem_req_o && !mem_gnt_i && !flush_i;
            hold_addr  = mem_addr_o;
            hold_wdata = mem_wdata_o;
            hold_be    = mem_be_o;
            hold_we    = mem_we_o;
            if (wb_valid_o) begin
                if (wb_q.size() == 0) begin
                    note_failure($sformatf("unexpected writeback for trans_id %0d",
                                           wb_trans_id_o));
                end else begin
                    e = wb_q.pop_front();
                    check_cnt++;
                    if (e.due != cyc) begin
                        report_error($sformatf("writeback at cycle %0d, expected %0d",
                                               cyc, e.due));
                    end
                    check_wb_id("wb_trans_id_o", wb_trans_id_o, e.id);
                    check_flag("wb_ex_valid_o", wb_ex_valid_o, e.ex);
                    if (e.ex) begin
                        check_cause("wb_cause_o", wb_cause_o, e.cause);
                        check_word("wb_tval_o", wb_tval_o, e.addr);
                    end
                end
            end else if (wb_q.size() != 0 && wb_q[0].due <= cyc) begin
                e = wb_q.pop_front();
                note_failure($sformatf("writeback for trans_id %0d never arrived", e.id));
            end
        end
    end

    always @(posedge clk_i) begin
        if (cyc > TIMEOUT) begin
            $display("timeout: run still busy after %0d cycles", cyc);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic tick();
        word_t r;
        @(posedge clk_i);
        if (gnt_random) begin
            r = rand_bits(1);
            mem_gnt_i <= r[0];
        end else begin
            mem_gnt_i <= gnt_level;
        end
    endtask

    task automatic drive_req(lsu_op_t op, word_t a, word_t b, word_t imm, logic en);
        lsu_valid_i            <= 1'b1;
        op_i                   <= op;
        operand_a_i            <= a;
        operand_b_i            <= b;
        imm_i                  <= imm;
        trans_id_i             <= next_id;
        en_ld_st_translation_i <= en;
        next_id = next_id + 3'd1;
    endtask

    // one request and a wait until the buffer is empty again
    task automatic issue(lsu_op_t op, word_t a, word_t b, word_t imm, logic en);
        tick();
        drive_req(op, a, b, imm, en);
        tick();
        lsu_valid_i <= 1'b0;
        @(negedge clk_i);
        while (!lsu_ready_o) begin
            tick();
            @(negedge clk_i);
        end
    endtask

    // grant held low so the request sits in the buffer when flush hits
    task automatic issue_and_flush(lsu_op_t op, word_t a, word_t b, word_t imm);
        tick();
        drive_req(op, a, b, imm, 1'b0);
        tick();
        lsu_valid_i <= 1'b0;
        flush_i     <= 1'b1;
        tick();
        flush_i <= 1'b0;
        @(negedge clk_i);
        check_flag("lsu_ready_o after flush", lsu_ready_o, 1'b1);
        check_flag("mem_req_o after flush", mem_req_o, 1'b0);
    endtask

    task automatic end_test(string name);
        while (mem_q.size() != 0 || wb_q.size() != 0) tick();
        // room for a stray writeback to show up
        repeat (NR_WB_REGS + 2) tick();
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
        test_err0 = err_cnt;
    endtask

    initial begin : stimulus
        word_t      a;
        word_t      b;
        word_t      r;
        lsu_op_t    op;
        logic [2:0] off;
        logic [2:0] mask;
        lfsr_q      = 32'hf9a7;
        next_id     = '0;
        gnt_random  = 1'b0;
        gnt_level   = 1'b0;
        rst_ni                 <= 1'b0;
        flush_i                <= 1'b0;
        lsu_valid_i            <= 1'b0;
        operand_a_i            <= '0;
        operand_b_i            <= '0;
        imm_i                  <= '0;
        op_i                   <= OP_LB;
        trans_id_i             <= '0;
        en_ld_st_translation_i <= 1'b0;
        mem_gnt_i              <= 1'b0;
        repeat (3) tick();
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_flag("mem_req_o after reset", mem_req_o, 1'b0);
        check_flag("wb_valid_o after reset", wb_valid_o, 1'b0);
        check_flag("lsu_ready_o after reset", lsu_ready_o, 1'b1);
        end_test("reset");

        // every operator aligned with grant tied high
        gnt_level = 1'b1;
        for (int c = 0; c < 12; c++) begin
            if (c != 7) begin
                repeat (3) begin
                    a = rand_bits(64);
                    a[2:0] = 3'b000;
                    issue(lsu_op_t'(c), a, rand_bits(64), small_imm(3'b000), 1'b0);
                end
            end
        end
        end_test("aligned");

        // offset forced off the size boundary
        for (int c = 0; c < 12; c++) begin
            op = lsu_op_t'(c);
            if (c != 7 && size_of(op) != 2'd0) begin
                repeat (2) begin
                    r    = rand_bits(3);
                    off  = r[2:0];
                    mask = 3'b111 >> (2'd3 - size_of(op));
                    if ((off & mask) == 3'b000) off = off | ((mask >> 1) + 3'b001);
                    a = rand_bits(64);
                    a[2:0] = 3'b000;
                    issue(op, a, rand_bits(64), small_imm(off), 1'b0);
                end
            end
        end
        end_test("misaligned");

        // bit 63 and bit 40 differ while bits 37:36 keep the carry away
        repeat (8) begin
            op = rand_op();
            a  = rand_bits(64);
            a[63]  = 1'b1;
            a[40]  = 1'b0;
            a[37]  = 1'b1;
            a[36]  = 1'b0;
            a[2:0] = 3'b000;
            b  = rand_bits(64);
            r  = rand_bits(3);
            r  = small_imm(r[2:0]);
            issue(op, a, b, r, 1'b1);
            issue(op, a, b, r, 1'b0);
        end
        end_test("translation");

        gnt_random = 1'b1;
        repeat (40) begin
            a = rand_bits(64);
            a[2:0] = 3'b000;
            r = rand_bits(3);
            issue(rand_op(), a, rand_bits(64), small_imm(r[2:0]), 1'b0);
        end
        end_test("back-pressure");

        gnt_random = 1'b0;
        gnt_level  = 1'b0;
        repeat (4) begin
            a = rand_bits(64);
            a[2:0] = 3'b000;
            issue_and_flush(rand_op(), a, rand_bits(64), small_imm(3'b000));
        end
        end_test("flush");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/lsu_pkg.sv
hw/lsu_req_if.sv
hw/lsu_agu.sv
hw/lsu_bypass.sv
hw/lsu_dispatch.sv
hw/lsu_wb_pipe.sv
hw/lsu_top.sv
dv/tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator and run it
# the run counts as passed only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_lsu -o sim_lsu \
    && ./obj_dir/sim_lsu | tee /dev/stderr | grep -qx '\*\* PASS \*\*' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
